// File: rv_isa_pkg.sv
// rv64i subset constants: widths, opcodes, funct codes, alu ops, result sources
`default_nettype none

package rv_isa_pkg;

  localparam int XLEN       = 64;
  localparam int REG_ADDR_W = 5;

  // major opcodes
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;

  localparam logic [2:0] F3_ADD = 3'b000;
  localparam logic [2:0] F3_XOR = 3'b100;
  localparam logic [2:0] F3_OR  = 3'b110;
  localparam logic [2:0] F3_AND = 3'b111;
  localparam logic [2:0] F3_BEQ = 3'b000;
  localparam logic [2:0] F3_BNE = 3'b001;
  // doubleword load/store width
  localparam logic [2:0] F3_D   = 3'b011;

  localparam logic [6:0] F7_SUB = 7'b0100000;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_PASS_B
  } alu_op_e;

  // where the writeback value comes from
  localparam logic [1:0] RES_ALU  = 2'd0;
  localparam logic [1:0] RES_MEM  = 2'd1;
  localparam logic [1:0] RES_LINK = 2'd2;

endpackage

`default_nettype wire

// File: cpu_cfg_pkg.sv
// core configuration: reset pc, fetch bus response codes, data ram size
`default_nettype none

package cpu_cfg_pkg;

  localparam logic [63:0] RESET_PC = 64'h0;

  // fetch bus response codes
  localparam logic [1:0] RESP_OKAY = 2'b00;

  localparam int DMEM_WORDS = 32;
  localparam int DMEM_AW    = 5;

endpackage

`default_nettype wire

// File: regfile.sv
// integer register file, 32 x 64, x0 hardwired to zero
`timescale 1ns/1ps
`default_nettype none

module regfile import rv_isa_pkg::*; (
  input  wire                  clk,
  input  wire                  i_rst_n,
  input  wire [REG_ADDR_W-1:0] i_rs1,
  input  wire [REG_ADDR_W-1:0] i_rs2,
  output logic [XLEN-1:0]      o_rs1_data,
  output logic [XLEN-1:0]      o_rs2_data,
  input  wire [REG_ADDR_W-1:0] i_rd,
  input  wire                  i_rd_wen,
  input  wire [XLEN-1:0]       i_rd_data
);

  logic [XLEN-1:0] regs [32];

  assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
  assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_rd_wen && i_rd != '0) begin
      regs[i_rd] <= i_rd_data;
    end
  end

endmodule

`default_nettype wire

// File: if_stage.sv
// fetch stage: pc register, fetch bus master, instruction select, trap flag
`timescale 1ns/1ps
`default_nettype none

module if_stage import rv_isa_pkg::*, cpu_cfg_pkg::*; (
  input  wire              clk,
  input  wire              i_rst_n,
  output logic             o_if_valid,
  input  wire              i_if_ready,
  input  wire [XLEN-1:0]   i_if_data_read,
  input  wire [1:0]        i_if_resp,
  output logic [XLEN-1:0]  o_if_addr,
  output logic             o_fetched_req,
  input  wire              i_fetched_ack,
  output logic [XLEN-1:0]  o_pc,
  output logic [31:0]      o_inst,
  input  wire              i_jmp,
  input  wire [XLEN-1:0]   i_jmp_addr,
  input  wire              i_executed_req,
  input  wire              i_executed_ack,
  input  wire              i_writebacked_req,
  output logic             o_writebacked_ack,
  output logic             o_trap
);

  logic            boot;
  logic            bus_accept;
  logic            jmp_q;
  logic [XLEN-1:0] jmp_addr_q;

  assign bus_accept        = o_if_valid && i_if_ready;
  assign o_if_addr         = o_pc;
  assign o_writebacked_ack = i_writebacked_req && !o_if_valid && !o_fetched_req;

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      boot          <= 1'b1;
      o_if_valid    <= 1'b0;
      o_fetched_req <= 1'b0;
      o_trap        <= 1'b0;
      jmp_q         <= 1'b0;
      o_pc          <= RESET_PC;
    end else begin
      boot <= 1'b0;
      // first fetch right after reset
      if (boot) begin
        o_if_valid <= 1'b1;
      end
      if (bus_accept) begin
        o_if_valid <= 1'b0;
        if (i_if_resp == RESP_OKAY) begin
          o_fetched_req <= 1'b1;
        end else begin
          o_trap <= 1'b1;
        end
      end
      if (o_fetched_req && i_fetched_ack) begin
        o_fetched_req <= 1'b0;
      end
      if (i_executed_req && i_executed_ack) begin
        jmp_q <= i_jmp;
      end
      // retired, move on to the next pc
      if (i_writebacked_req && o_writebacked_ack) begin
        o_pc       <= jmp_q ? jmp_addr_q : o_pc + XLEN'(4);
        o_if_valid <= !o_trap;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (bus_accept) begin
      o_inst <= o_pc[2] ? i_if_data_read[63:32] : i_if_data_read[31:0];
    end
    if (i_executed_req && i_executed_ack) begin
      jmp_addr_q <= i_jmp_addr;
    end
  end

  // stalled request keeps valid and address
  assert property (@(posedge clk) disable iff (!i_rst_n)
    o_if_valid && !i_if_ready |=> o_if_valid && $stable(o_if_addr));

endmodule

`default_nettype wire

// File: id_stage.sv
// decode stage: instruction decoder, register reads, operand and immediate select
`timescale 1ns/1ps
`default_nettype none

module id_stage import rv_isa_pkg::*; (
  input  wire                   clk,
  input  wire                   i_rst_n,
  input  wire                   i_fetched_req,
  output logic                  o_fetched_ack,
  input  wire [31:0]            i_inst,
  input  wire [XLEN-1:0]        i_pc,
  output logic [REG_ADDR_W-1:0] o_rs1,
  output logic [REG_ADDR_W-1:0] o_rs2,
  input  wire [XLEN-1:0]        i_rs1_data,
  input  wire [XLEN-1:0]        i_rs2_data,
  output logic                  o_decoded_req,
  input  wire                   i_decoded_ack,
  output alu_op_e               o_alu_op,
  output logic [XLEN-1:0]       o_op1,
  output logic [XLEN-1:0]       o_op2,
  output logic [XLEN-1:0]       o_store_data,
  output logic [XLEN-1:0]       o_imm,
  output logic [XLEN-1:0]       o_pc,
  output logic [REG_ADDR_W-1:0] o_rd,
  output logic                  o_rd_wen,
  output logic [1:0]            o_res_sel,
  output logic                  o_br,
  output logic                  o_br_ne,
  output logic                  o_jal,
  output logic                  o_memwen
);

  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_j;
  alu_op_e         alu_d;
  logic [XLEN-1:0] op2_d;
  logic [XLEN-1:0] imm_d;
  logic [1:0]      res_d;
  logic            rd_wen_d;
  logic            br_d;
  logic            jal_d;
  logic            memwen_d;
  logic            xfer;

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign o_rs1  = i_inst[19:15];
  assign o_rs2  = i_inst[24:20];

  assign imm_i = {{52{i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{52{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{52{i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_u = {{32{i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_j = {{44{i_inst[31]}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  assign o_fetched_ack = i_fetched_req && !o_decoded_req;
  assign xfer          = i_fetched_req && o_fetched_ack;

  // unknown encodings fall through as a no-op
  always_comb begin
    alu_d    = ALU_ADD;
    op2_d    = i_rs2_data;
    imm_d    = '0;
    res_d    = RES_ALU;
    rd_wen_d = 1'b0;
    br_d     = 1'b0;
    jal_d    = 1'b0;
    memwen_d = 1'b0;
    case (opcode)
      OPC_OP, OPC_OP_IMM: begin
        rd_wen_d = 1'b1;
        if (opcode == OPC_OP_IMM) begin
          op2_d = imm_i;
        end
        case (funct3)
          F3_ADD: begin
            if (opcode == OPC_OP && i_inst[31:25] == F7_SUB) begin
              alu_d = ALU_SUB;
            end
          end
          F3_XOR:  alu_d = ALU_XOR;
          F3_OR:   alu_d = ALU_OR;
          F3_AND:  alu_d = ALU_AND;
          default: rd_wen_d = 1'b0;
        endcase
      end
      OPC_LUI: begin
        alu_d    = ALU_PASS_B;
        op2_d    = imm_u;
        rd_wen_d = 1'b1;
      end
      OPC_BRANCH: begin
        imm_d = imm_b;
        br_d  = (funct3 == F3_BEQ) || (funct3 == F3_BNE);
      end
      OPC_JAL: begin
        imm_d    = imm_j;
        jal_d    = 1'b1;
        rd_wen_d = 1'b1;
        res_d    = RES_LINK;
      end
      OPC_LOAD: begin
        imm_d    = imm_i;
        rd_wen_d = (funct3 == F3_D);
        res_d    = RES_MEM;
      end
      OPC_STORE: begin
        imm_d    = imm_s;
        memwen_d = (funct3 == F3_D);
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      o_decoded_req <= 1'b0;
      o_rd_wen      <= 1'b0;
      o_br          <= 1'b0;
      o_jal         <= 1'b0;
      o_memwen      <= 1'b0;
    end else if (xfer) begin
      o_decoded_req <= 1'b1;
      o_rd_wen      <= rd_wen_d;
      o_br          <= br_d;
      o_jal         <= jal_d;
      o_memwen      <= memwen_d;
    end else if (i_decoded_ack) begin
      o_decoded_req <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (xfer) begin
      o_alu_op     <= alu_d;
      o_op1        <= i_rs1_data;
      o_op2        <= op2_d;
      o_store_data <= i_rs2_data;
      o_imm        <= imm_d;
      o_pc         <= i_pc;
      o_rd         <= i_inst[11:7];
      o_res_sel    <= res_d;
      o_br_ne      <= (funct3 == F3_BNE);
    end
  end

endmodule

`default_nettype wire

// File: exe_stage.sv
// execute stage: alu, branch compare, jump target, data address generation
`timescale 1ns/1ps
`default_nettype none

module exe_stage import rv_isa_pkg::*; (
  input  wire                   clk,
  input  wire                   i_rst_n,
  input  wire                   i_decoded_req,
  output logic                  o_decoded_ack,
  input  alu_op_e               i_alu_op,
  input  wire [XLEN-1:0]        i_op1,
  input  wire [XLEN-1:0]        i_op2,
  input  wire [XLEN-1:0]        i_store_data,
  input  wire [XLEN-1:0]        i_imm,
  input  wire [XLEN-1:0]        i_pc,
  input  wire [REG_ADDR_W-1:0]  i_rd,
  input  wire                   i_rd_wen,
  input  wire [1:0]             i_res_sel,
  input  wire                   i_br,
  input  wire                   i_br_ne,
  input  wire                   i_jal,
  input  wire                   i_memwen,
  output logic                  o_executed_req,
  input  wire                   i_executed_ack,
  output logic [XLEN-1:0]       o_result,
  output logic [XLEN-1:0]       o_memaddr,
  output logic [XLEN-1:0]       o_memwdata,
  output logic                  o_memwen,
  output logic [1:0]            o_res_sel,
  output logic [REG_ADDR_W-1:0] o_rd,
  output logic                  o_rd_wen,
  output logic [XLEN-1:0]       o_pc,
  output logic                  o_jmp,
  output logic [XLEN-1:0]       o_jmp_addr
);

  logic [XLEN-1:0] alu_out;
  logic            taken;
  logic            xfer;

  assign o_decoded_ack = i_decoded_req && !o_executed_req;
  assign xfer          = i_decoded_req && o_decoded_ack;

  always_comb begin
    case (i_alu_op)
      ALU_SUB:    alu_out = i_op1 - i_op2;
      ALU_AND:    alu_out = i_op1 & i_op2;
      ALU_OR:     alu_out = i_op1 | i_op2;
      ALU_XOR:    alu_out = i_op1 ^ i_op2;
      ALU_PASS_B: alu_out = i_op2;
      default:    alu_out = i_op1 + i_op2;
    endcase
  end

  // beq takes on equal, bne on not equal
  assign taken = i_jal || (i_br && ((i_op1 == i_op2) != i_br_ne));

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      o_executed_req <= 1'b0;
      o_memwen       <= 1'b0;
      o_rd_wen       <= 1'b0;
      o_jmp          <= 1'b0;
    end else if (xfer) begin
      o_executed_req <= 1'b1;
      o_memwen       <= i_memwen;
      o_rd_wen       <= i_rd_wen;
      o_jmp          <= taken;
    end else if (i_executed_ack) begin
      o_executed_req <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (xfer) begin
      o_result   <= (i_res_sel == RES_LINK) ? i_pc + XLEN'(4) : alu_out;
      o_memaddr  <= i_op1 + i_imm;
      o_memwdata <= i_store_data;
      o_res_sel  <= i_res_sel;
      o_rd       <= i_rd;
      o_pc       <= i_pc;
      o_jmp_addr <= i_pc + i_imm;
    end
  end

  // request is only withdrawn after the memory stage took it
  assert property (@(posedge clk) disable iff (!i_rst_n)
    o_executed_req && !i_executed_ack |=> o_executed_req);

endmodule

`default_nettype wire

// File: mem_stage.sv
// memory stage: data ram with doubleword load and store
`timescale 1ns/1ps
`default_nettype none

module mem_stage import rv_isa_pkg::*, cpu_cfg_pkg::*; (
  input  wire                   clk,
  input  wire                   i_rst_n,
  input  wire                   i_executed_req,
  output logic                  o_executed_ack,
  input  wire [XLEN-1:0]        i_memaddr,
  input  wire [XLEN-1:0]        i_memwdata,
  input  wire                   i_memwen,
  input  wire [XLEN-1:0]        i_result,
  input  wire [1:0]             i_res_sel,
  input  wire [REG_ADDR_W-1:0]  i_rd,
  input  wire                   i_rd_wen,
  input  wire [XLEN-1:0]        i_pc,
  output logic                  o_memoryed_req,
  input  wire                   i_memoryed_ack,
  output logic [XLEN-1:0]       o_wdata,
  output logic [REG_ADDR_W-1:0] o_rd,
  output logic                  o_rd_wen,
  output logic [XLEN-1:0]       o_pc
);

  logic [XLEN-1:0]    ram [DMEM_WORDS];
  logic [DMEM_AW-1:0] idx;
  logic               xfer;

  // doubleword index, address bits 7:3
  assign idx            = i_memaddr[DMEM_AW+2:3];
  assign o_executed_ack = i_executed_req && !o_memoryed_req;
  assign xfer           = i_executed_req && o_executed_ack;

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      o_memoryed_req <= 1'b0;
      o_rd_wen       <= 1'b0;
    end else if (xfer) begin
      o_memoryed_req <= 1'b1;
      o_rd_wen       <= i_rd_wen;
    end else if (i_memoryed_ack) begin
      o_memoryed_req <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (xfer) begin
      if (i_memwen) begin
        ram[idx] <= i_memwdata;
      end
      o_wdata <= (i_res_sel == RES_MEM) ? ram[idx] : i_result;
      o_rd    <= i_rd;
      o_pc    <= i_pc;
    end
  end

endmodule

`default_nettype wire

// File: wb_stage.sv
// writeback stage with result register, register file write and commit port
`timescale 1ns/1ps
`default_nettype none

module wb_stage import rv_isa_pkg::*; (
  input  wire                   clk,
  input  wire                   i_rst_n,
  input  wire                   i_memoryed_req,
  output logic                  o_memoryed_ack,
  input  wire [XLEN-1:0]        i_wdata,
  input  wire [REG_ADDR_W-1:0]  i_rd,
  input  wire                   i_rd_wen,
  input  wire [XLEN-1:0]        i_pc,
  output logic [REG_ADDR_W-1:0] o_rf_rd,
  output logic                  o_rf_wen,
  output logic [XLEN-1:0]       o_rf_wdata,
  output logic                  o_writebacked_req,
  input  wire                   i_writebacked_ack,
  output logic                  o_cmt_valid,
  output logic [XLEN-1:0]       o_cmt_pc,
  output logic [REG_ADDR_W-1:0] o_cmt_rd,
  output logic                  o_cmt_wen,
  output logic [XLEN-1:0]       o_cmt_wdata
);

  logic xfer;

  assign o_memoryed_ack = i_memoryed_req && !o_writebacked_req;
  assign xfer           = i_memoryed_req && o_memoryed_ack;

  assign o_rf_rd    = o_cmt_rd;
  assign o_rf_wen   = o_cmt_valid && o_cmt_wen;
  assign o_rf_wdata = o_cmt_wdata;

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      o_cmt_valid       <= 1'b0;
      o_writebacked_req <= 1'b0;
      o_cmt_wen         <= 1'b0;
    end else begin
      o_cmt_valid <= xfer;
      if (xfer) begin
        o_writebacked_req <= 1'b1;
        o_cmt_wen         <= i_rd_wen;
      end else if (i_writebacked_ack) begin
        o_writebacked_req <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (xfer) begin
      o_cmt_pc    <= i_pc;
      o_cmt_rd    <= i_rd;
      o_cmt_wdata <= i_wdata;
    end
  end

  // one commit per instruction
  assert property (@(posedge clk) disable iff (!i_rst_n)
    o_cmt_valid |=> !o_cmt_valid);

endmodule

`default_nettype wire

// File: cpu.sv
// top level: five-stage core and register file
`timescale 1ns/1ps
`default_nettype none

module cpu import rv_isa_pkg::*; (
  input  wire                   clk,
  input  wire                   i_rst_n,
  output logic                  o_if_valid,
  input  wire                   i_if_ready,
  input  wire [XLEN-1:0]        i_if_data_read,
  input  wire [1:0]             i_if_resp,
  output logic [XLEN-1:0]       o_if_addr,
  output logic                  o_cmt_valid,
  output logic [XLEN-1:0]       o_cmt_pc,
  output logic [REG_ADDR_W-1:0] o_cmt_rd,
  output logic                  o_cmt_wen,
  output logic [XLEN-1:0]       o_cmt_wdata,
  output logic                  o_trap
);

  // stage handshakes
  logic fetched_req, fetched_ack;
  logic decoded_req, decoded_ack;
  logic executed_req, executed_ack;
  logic memoryed_req, memoryed_ack;
  logic writebacked_req, writebacked_ack;

  // if -> id
  logic [XLEN-1:0]       if_pc;
  logic [31:0]           if_inst;
  // id <-> regfile
  logic [REG_ADDR_W-1:0] id_rs1, id_rs2;
  logic [XLEN-1:0]       rf_rs1_data, rf_rs2_data;
  // id -> exe
  alu_op_e               id_alu_op;
  logic [XLEN-1:0]       id_op1, id_op2, id_store_data, id_imm, id_pc;
  logic [REG_ADDR_W-1:0] id_rd;
  logic                  id_rd_wen, id_br, id_br_ne, id_jal, id_memwen;
  logic [1:0]            id_res_sel;
  // exe -> mem, exe -> if
  logic [XLEN-1:0]       ex_result, ex_memaddr, ex_memwdata, ex_pc, ex_jmp_addr;
  logic                  ex_memwen, ex_rd_wen, ex_jmp;
  logic [1:0]            ex_res_sel;
  logic [REG_ADDR_W-1:0] ex_rd;
  // mem -> wb
  logic [XLEN-1:0]       mem_wdata, mem_pc;
  logic [REG_ADDR_W-1:0] mem_rd;
  logic                  mem_rd_wen;
  // wb -> regfile
  logic [REG_ADDR_W-1:0] wb_rd;
  logic                  wb_wen;
  logic [XLEN-1:0]       wb_wdata;

  if_stage u_if_stage (
    .clk               (clk),             .i_rst_n           (i_rst_n),
    .o_if_valid        (o_if_valid),      .i_if_ready        (i_if_ready),
    .i_if_data_read    (i_if_data_read),  .i_if_resp         (i_if_resp),
    .o_if_addr         (o_if_addr),
    .o_fetched_req     (fetched_req),     .i_fetched_ack     (fetched_ack),
    .o_pc              (if_pc),           .o_inst            (if_inst),
    .i_jmp             (ex_jmp),          .i_jmp_addr        (ex_jmp_addr),
    .i_executed_req    (executed_req),    .i_executed_ack    (executed_ack),
    .i_writebacked_req (writebacked_req), .o_writebacked_ack (writebacked_ack),
    .o_trap            (o_trap)
  );

  id_stage u_id_stage (
    .clk           (clk),           .i_rst_n       (i_rst_n),
    .i_fetched_req (fetched_req),   .o_fetched_ack (fetched_ack),
    .i_inst        (if_inst),       .i_pc          (if_pc),
    .o_rs1         (id_rs1),        .o_rs2         (id_rs2),
    .i_rs1_data    (rf_rs1_data),   .i_rs2_data    (rf_rs2_data),
    .o_decoded_req (decoded_req),   .i_decoded_ack (decoded_ack),
    .o_alu_op      (id_alu_op),     .o_op1         (id_op1),
    .o_op2         (id_op2),        .o_store_data  (id_store_data),
    .o_imm         (id_imm),        .o_pc          (id_pc),
    .o_rd          (id_rd),         .o_rd_wen      (id_rd_wen),
    .o_res_sel     (id_res_sel),    .o_br          (id_br),
    .o_br_ne       (id_br_ne),      .o_jal         (id_jal),
    .o_memwen      (id_memwen)
  );

  exe_stage u_exe_stage (
    .clk            (clk),          .i_rst_n        (i_rst_n),
    .i_decoded_req  (decoded_req),  .o_decoded_ack  (decoded_ack),
    .i_alu_op       (id_alu_op),    .i_op1          (id_op1),
    .i_op2          (id_op2),       .i_store_data   (id_store_data),
    .i_imm          (id_imm),       .i_pc           (id_pc),
    .i_rd           (id_rd),        .i_rd_wen       (id_rd_wen),
    .i_res_sel      (id_res_sel),   .i_br           (id_br),
    .i_br_ne        (id_br_ne),     .i_jal          (id_jal),
    .i_memwen       (id_memwen),
    .o_executed_req (executed_req), .i_executed_ack (executed_ack),
    .o_result       (ex_result),    .o_memaddr      (ex_memaddr),
    .o_memwdata     (ex_memwdata),  .o_memwen       (ex_memwen),
    .o_res_sel      (ex_res_sel),   .o_rd           (ex_rd),
    .o_rd_wen       (ex_rd_wen),    .o_pc           (ex_pc),
    .o_jmp          (ex_jmp),       .o_jmp_addr     (ex_jmp_addr)
  );

  mem_stage u_mem_stage (
    .clk            (clk),          .i_rst_n        (i_rst_n),
    .i_executed_req (executed_req), .o_executed_ack (executed_ack),
    .i_memaddr      (ex_memaddr),   .i_memwdata     (ex_memwdata),
    .i_memwen       (ex_memwen),    .i_result       (ex_result),
    .i_res_sel      (ex_res_sel),   .i_rd           (ex_rd),
    .i_rd_wen       (ex_rd_wen),    .i_pc           (ex_pc),
    .o_memoryed_req (memoryed_req), .i_memoryed_ack (memoryed_ack),
    .o_wdata        (mem_wdata),    .o_rd           (mem_rd),
    .o_rd_wen       (mem_rd_wen),   .o_pc           (mem_pc)
  );

  wb_stage u_wb_stage (
    .clk               (clk),             .i_rst_n           (i_rst_n),
    .i_memoryed_req    (memoryed_req),    .o_memoryed_ack    (memoryed_ack),
    .i_wdata           (mem_wdata),       .i_rd              (mem_rd),
    .i_rd_wen          (mem_rd_wen),      .i_pc              (mem_pc),
    .o_rf_rd           (wb_rd),           .o_rf_wen          (wb_wen),
    .o_rf_wdata        (wb_wdata),
    .o_writebacked_req (writebacked_req), .i_writebacked_ack (writebacked_ack),
    .o_cmt_valid       (o_cmt_valid),     .o_cmt_pc          (o_cmt_pc),
    .o_cmt_rd          (o_cmt_rd),        .o_cmt_wen         (o_cmt_wen),
    .o_cmt_wdata       (o_cmt_wdata)
  );

  regfile u_regfile (
    .clk        (clk),         .i_rst_n    (i_rst_n),
    .i_rs1      (id_rs1),      .i_rs2      (id_rs2),
    .o_rs1_data (rf_rs1_data), .o_rs2_data (rf_rs2_data),
    .i_rd       (wb_rd),       .i_rd_wen   (wb_wen),
    .i_rd_data  (wb_wdata)
  );

endmodule

`default_nettype wire

// File: tb_cpu.sv
// cpu testbench with pattern loader, fetch bus model, commit checker and timeout
`timescale 1ns/1ps
`default_nettype none

module tb_cpu import rv_isa_pkg::*, cpu_cfg_pkg::*; ();

  localparam int         IMEM_WORDS = 64;
  localparam int         MAX_EXP    = 64;
  localparam logic [1:0] RESP_ERR   = 2'b10;

  logic                  clk = 1'b0;
  logic                  i_rst_n = 1'b0;
  logic                  i_if_ready = 1'b0;
  logic [XLEN-1:0]       i_if_data_read = '0;
  logic [1:0]            i_if_resp = RESP_OKAY;
  wire                   o_if_valid;
  wire [XLEN-1:0]        o_if_addr;
  wire                   o_cmt_valid;
  wire [XLEN-1:0]        o_cmt_pc;
  wire [REG_ADDR_W-1:0]  o_cmt_rd;
  wire                   o_cmt_wen;
  wire [XLEN-1:0]        o_cmt_wdata;
  wire                   o_trap;

  logic [31:0]           imem [IMEM_WORDS];
  logic [XLEN-1:0]       exp_pc [MAX_EXP];
  logic [REG_ADDR_W-1:0] exp_rd [MAX_EXP];
  logic                  exp_wen [MAX_EXP];
  logic [XLEN-1:0]       exp_wdata [MAX_EXP];
  logic [XLEN-1:0]       fault_addr = '1;
  logic [XLEN-1:0]       held_addr = '0;
  logic                  busy = 1'b0;
  integer                seed;
  int                    wait_cnt = 0;
  int                    n_fetch = 0;
  int                    n_exp = 0;
  int                    n_cmt = 0;
  int                    checks = 0;
  int                    errors = 0;
  int                    cycles = 0;

  cpu i_dut (
    .clk            (clk),
    .i_rst_n        (i_rst_n),
    .o_if_valid     (o_if_valid),
    .i_if_ready     (i_if_ready),
    .i_if_data_read (i_if_data_read),
    .i_if_resp      (i_if_resp),
    .o_if_addr      (o_if_addr),
    .o_cmt_valid    (o_cmt_valid),
    .o_cmt_pc       (o_cmt_pc),
    .o_cmt_rd       (o_cmt_rd),
    .o_cmt_wen      (o_cmt_wen),
    .o_cmt_wdata    (o_cmt_wdata),
    .o_trap         (o_trap)
  );

  always #10 clk = ~clk;

  task automatic compare_value(input string name, input logic [XLEN-1:0] got,
                               input logic [XLEN-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s: got %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic load_patterns();
    integer           fd;
    integer           code;
    logic [7:0]       tag;
    logic [XLEN-1:0]  a;
    logic [XLEN-1:0]  b;
    logic [XLEN-1:0]  c;
    logic [XLEN-1:0]  d;
    logic [8*120-1:0] rest;
    logic             done;
    fd = $fopen("cpu_patterns.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("cannot open cpu_patterns.txt");
    end else begin
      done = 1'b0;
      while (!done) begin
        code = $fscanf(fd, " %c", tag);
        if (code != 1) begin
          done = 1'b1;
        end else if (tag == "#") begin
          code = $fgets(rest, fd);
        end else if (tag == "I") begin
          code = $fscanf(fd, "%h %h", a, b);
          imem[a[7:2]] = b[31:0];
        end else if (tag == "E" && n_exp < MAX_EXP) begin
          code = $fscanf(fd, "%h %h %h %h", a, b, c, d);
          exp_pc[n_exp]    = a;
          exp_rd[n_exp]    = b[REG_ADDR_W-1:0];
          exp_wen[n_exp]   = c[0];
          exp_wdata[n_exp] = d;
          n_exp++;
        end else if (tag == "F") begin
          code = $fscanf(fd, "%h", a);
          fault_addr = a;
        end else begin
          errors++;
          done = 1'b1;
          $display("bad line in cpu_patterns.txt with tag %c", tag);
        end
      end
      $fclose(fd);
    end
  endtask

  // 64-bit read word holding the addressed instruction
  function automatic logic [XLEN-1:0] fetch_word(input logic [XLEN-1:0] addr);
    return {imem[{addr[7:3], 1'b1}], imem[{addr[7:3], 1'b0}]};
  endfunction

  // instruction memory slave with random ready delay
  always @(posedge clk) begin
    if (!i_rst_n) begin
      i_if_ready     <= 1'b0;
      i_if_resp      <= RESP_OKAY;
      i_if_data_read <= '0;
      busy = 1'b0;
    end else if (o_if_valid && i_if_ready) begin
      i_if_ready <= 1'b0;
      busy = 1'b0;
    end else if (o_if_valid) begin
      if (!busy) begin
        busy      = 1'b1;
        held_addr = o_if_addr;
        wait_cnt  = $random(seed) & 3;
        if (n_fetch == 0) begin
          compare_value("o_if_addr", o_if_addr, RESET_PC);
        end
        n_fetch++;
      end else begin
        compare_value("o_if_addr", o_if_addr, held_addr);
      end
      if (wait_cnt == 0) begin
        i_if_ready     <= 1'b1;
        i_if_data_read <= fetch_word(o_if_addr);
        i_if_resp      <= (o_if_addr == fault_addr) ? RESP_ERR : RESP_OKAY;
      end else begin
        wait_cnt--;
      end
    end
  end

  always @(posedge clk) begin
    if (i_rst_n && o_cmt_valid) begin
      if (n_cmt < n_exp) begin
        compare_value("o_cmt_pc", o_cmt_pc, exp_pc[n_cmt]);
        compare_value("o_cmt_wen", XLEN'(o_cmt_wen), XLEN'(exp_wen[n_cmt]));
        // rd and data only mean something for a register write
        if (exp_wen[n_cmt]) begin
          compare_value("o_cmt_rd", XLEN'(o_cmt_rd), XLEN'(exp_rd[n_cmt]));
          compare_value("o_cmt_wdata", o_cmt_wdata, exp_wdata[n_cmt]);
        end
      end else begin
        errors++;
        $display("unexpected commit at pc %h after the last expected one", o_cmt_pc);
      end
      n_cmt++;
    end
    if (i_rst_n && o_trap && o_if_valid) begin
      errors++;
      $display("fetch issued at %h after the trap was raised", o_if_addr);
    end
  end

  initial begin
    int limit;
    seed = 32'hcb76_ecc3;
    for (int i = 0; i < IMEM_WORDS; i++) begin
      imem[i] = {25'(i), 7'h7f};
    end
    load_patterns();
    limit = n_exp * 9 + 100;

    repeat (2) @(posedge clk);
    compare_value("o_if_valid", XLEN'(o_if_valid), '0);
    compare_value("o_cmt_valid", XLEN'(o_cmt_valid), '0);
    compare_value("o_trap", XLEN'(o_trap), '0);
    i_rst_n <= 1'b1;

    while (!o_trap && cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    if (!o_trap) begin
      errors++;
      $display("timeout after %0d cycles without a trap", cycles);
    end else begin
      // no commit may follow the trap
      repeat (20) @(posedge clk);
    end
    if (n_cmt < n_exp) begin
      errors++;
      $display("%0d expected commits never appeared, first one at pc %h",
               n_exp - n_cmt, exp_pc[n_cmt]);
    end

    $display("%0d checks, %0d errors, %0d of %0d commits seen", checks, errors, n_cmt, n_exp);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: cpu_patterns.txt
# I lines give byte address and instruction word and F gives the faulting fetch address
# E lines give pc rd wen wdata of each commit in order where rd and wdata count when wen is 1
I 00 12300093
I 04 fff00113
I 08 0ff0c193
I 0c 80000237
I 10 001202b3
I 14 40208333
I 18 0032f3b3
I 1c 00326433
I 20 7f017493
I 24 0550e013
I 28 00100533
I 2c 0054b823
I 30 0014b423
I 34 0104b583
I 38 0084b603
I 3c 00558463
I 40 00100693
I 44 00a09463
I 48 0080076f
I 4c 00200793
I 50 00470813
F 54
E 00 01 1 0000000000000123
E 04 02 1 ffffffffffffffff
E 08 03 1 00000000000001dc
E 0c 04 1 ffffffff80000000
E 10 05 1 ffffffff80000123
E 14 06 1 0000000000000124
E 18 07 1 0000000000000100
E 1c 08 1 ffffffff800001dc
E 20 09 1 00000000000007f0
E 24 00 1 0000000000000177
E 28 0a 1 0000000000000123
E 2c 00 0 0
E 30 00 0 0
E 34 0b 1 ffffffff80000123
E 38 0c 1 0000000000000123
E 3c 00 0 0
E 44 00 0 0
E 48 0e 1 000000000000004c
E 50 10 1 0000000000000050

// File: verilog.f
rv_isa_pkg.sv
cpu_cfg_pkg.sv
regfile.sv
if_stage.sv
id_stage.sv
exe_stage.sv
mem_stage.sv
wb_stage.sv
cpu.sv
tb_cpu.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f verilog.f --top-module tb_cpu -Mdir obj_dir -o tb_cpu
	./obj_dir/tb_cpu > sim.log 2>&1
	cat sim.log
	! grep -q "Finished with errors" sim.log

clean:
	rm -rf obj_dir sim.log
